//--- source/mem_pkg.sv
package mem_pkg;

    // op code layout {access, size[1:0], write, unsigned}
    typedef logic [4:0] mem_op_t;

    localparam int op_access_bit   = 4;
    localparam int op_size_hi      = 3;
    localparam int op_size_lo      = 2;
    localparam int op_write_bit    = 1;
    localparam int op_unsigned_bit = 0;

    // access size codes, code 2 unused
    localparam logic [1:0] size_byte = 2'd0;
    localparam logic [1:0] size_half = 2'd1;
    localparam logic [1:0] size_word = 2'd3;

    // word ram geometry, index from addr[9:2]
    localparam int mem_words  = 256;
    localparam int mem_addr_w = 8;

    // cycles from first sight of a request to ok
    localparam int mem_latency = 2;

    // latency counter sizing
    localparam int lat_cnt_w = $clog2(mem_latency + 1);

    typedef logic [lat_cnt_w-1:0] lat_cnt_t;

    localparam lat_cnt_t lat_done = lat_cnt_t'(mem_latency);

endpackage

//--- source/pipe_pkg.sv
package pipe_pkg;

    // datapath width
    localparam int data_w = 32;

    // register file address width
    localparam int reg_addr_w = 5;

    typedef logic [data_w-1:0] word_t;

    typedef logic [reg_addr_w-1:0] reg_addr_t;

    // carried from address stage to memory stage
    // addr is base + offset, also the alu result for non-access ops
    typedef struct packed {
        logic              we;
        reg_addr_t         wa;
        word_t             addr;
        word_t             store_data;
        mem_pkg::mem_op_t  op;
    } ex_payload_t;

    // carried from memory stage to writeback
    typedef struct packed {
        logic       we;
        reg_addr_t  wa;
        word_t      data;
    } wb_payload_t;

    // 1 + 5 + 32 + 32 + 5 bits
    // 1 + 5 + 32 bits

endpackage

//--- source/stage_buffer.sv
`timescale 1ns/1ps

module stage_buffer #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rst,

    input  logic     in_valid_i,
    input  payload_t in_payload_i,
    output logic     in_ready_o,

    output logic     out_valid_o,
    output payload_t out_payload_o,
    input  logic     out_ready_i
);

    // single slot
    logic     full_q;
    payload_t data_q;

    // can load when empty or being emptied this cycle
    assign in_ready_o = !full_q || out_ready_i;

    assign out_valid_o   = full_q;
    assign out_payload_o = data_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            full_q <= 1'b0;
        end else if (in_ready_o) begin
            full_q <= in_valid_i;
        end
    end

    // payload only moves on a real transfer
    always_ff @(posedge clk) begin
        if (in_valid_i && in_ready_o) begin
            data_q <= in_payload_i;
        end
    end

endmodule

//--- source/addr_stage.sv
`timescale 1ns/1ps

module addr_stage (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  in_valid_i,
    output logic                  in_ready_o,
    input  logic                  in_we_i,
    input  pipe_pkg::reg_addr_t   in_wa_i,
    input  pipe_pkg::word_t       in_base_i,
    input  pipe_pkg::word_t       in_offset_i,
    input  pipe_pkg::word_t       in_store_data_i,
    input  mem_pkg::mem_op_t      in_mem_op_i,

    output logic                  out_valid_o,
    output pipe_pkg::ex_payload_t out_payload_o,
    input  logic                  out_ready_i
);

    // input transfer this cycle
    logic take;

    // free when empty or downstream drains us now
    assign in_ready_o = !out_valid_o || out_ready_i;
    assign take       = in_valid_i && in_ready_o;

    // valid flag follows the input whenever the slot can move
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid_o <= 1'b0;
        end else if (in_ready_o) begin
            out_valid_o <= in_valid_i;
        end
    end

    // effective address add, registered with the rest of the op
    // non-access ops write this sum back unchanged
    always_ff @(posedge clk) begin
        if (take) begin
            out_payload_o.we         <= in_we_i;
            out_payload_o.wa         <= in_wa_i;
            out_payload_o.addr       <= in_base_i + in_offset_i;
            out_payload_o.store_data <= in_store_data_i;
            out_payload_o.op         <= in_mem_op_i;
        end
    end

endmodule

//--- source/mem_stage.sv
`timescale 1ns/1ps

module mem_stage (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  in_valid_i,
    input  pipe_pkg::ex_payload_t in_payload_i,
    output logic                  in_ready_o,

    output logic                  out_valid_o,
    output pipe_pkg::wb_payload_t out_payload_o,
    input  logic                  out_ready_i,

    output logic                  req_o,
    output pipe_pkg::word_t       addr_o,
    output pipe_pkg::word_t       wdata_o,
    output logic                  write_o,
    output logic [1:0]            size_o,
    input  logic                  ok_i,
    input  pipe_pkg::word_t       rdata_i
);

    typedef enum logic [1:0] {st_idle, st_wait, st_hold} state_t;

    state_t                state_q;
    state_t                state_d;
    // high the cycle after ok, keeps req low for one cycle
    logic                  gap_q;
    pipe_pkg::wb_payload_t res_q;
    pipe_pkg::wb_payload_t pass_res;
    pipe_pkg::wb_payload_t acc_res;
    logic                  is_access;
    logic                  is_uns;

    // pick lane, then sign or zero extend
    function automatic pipe_pkg::word_t load_extend(
        input pipe_pkg::word_t raw,
        input logic [1:0]      lane,
        input logic [1:0]      size,
        input logic            uns
    );
        logic [7:0]      b;
        logic [15:0]     h;
        pipe_pkg::word_t res;
        b = raw[{lane, 3'b000} +: 8];
        // halfword ignores addr bit 0
        h = lane[1] ? raw[31:16] : raw[15:0];
        case (size)
            mem_pkg::size_byte: res = uns ? {24'h0, b} : {{24{b[7]}}, b};
            mem_pkg::size_half: res = uns ? {16'h0, h} : {{16{h[15]}}, h};
            // word ignores the unsigned flag
            mem_pkg::size_word: res = raw;
            default:            res = raw;
        endcase
        return res;
    endfunction

    assign is_access = in_payload_i.op[mem_pkg::op_access_bit];
    assign is_uns    = in_payload_i.op[mem_pkg::op_unsigned_bit];

    // request fields straight from the held op
    assign addr_o  = in_payload_i.addr;
    assign wdata_o = in_payload_i.store_data;
    assign write_o = in_payload_i.op[mem_pkg::op_write_bit];
    assign size_o  = in_payload_i.op[mem_pkg::op_size_hi:mem_pkg::op_size_lo];

    // non-access result is the address sum
    assign pass_res.we   = in_payload_i.we;
    assign pass_res.wa   = in_payload_i.wa;
    assign pass_res.data = in_payload_i.addr;

    // stores also write back the address
    assign acc_res.we   = in_payload_i.we;
    assign acc_res.wa   = in_payload_i.wa;
    assign acc_res.data = write_o ? in_payload_i.addr
                                  : load_extend(rdata_i, in_payload_i.addr[1:0], size_o, is_uns);

    always_comb begin
        state_d       = state_q;
        req_o         = 1'b0;
        in_ready_o    = 1'b0;
        out_valid_o   = 1'b0;
        out_payload_o = pass_res;
        case (state_q)
            st_idle: begin
                if (in_valid_i && !is_access) begin
                    // same-cycle pass-through
                    out_valid_o = 1'b1;
                    in_ready_o  = out_ready_i;
                end else if (in_valid_i && !gap_q) begin
                    // first request cycle
                    req_o   = 1'b1;
                    state_d = st_wait;
                end
            end
            st_wait: begin
                req_o = 1'b1;
                if (ok_i) begin
                    out_valid_o   = 1'b1;
                    out_payload_o = acc_res;
                    in_ready_o    = out_ready_i;
                    state_d       = out_ready_i ? st_idle : st_hold;
                end
            end
            default: begin
                // answer parked, no reissue
                out_valid_o   = 1'b1;
                out_payload_o = res_q;
                in_ready_o    = out_ready_i;
                if (out_ready_i) begin
                    state_d = st_idle;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= st_idle;
            gap_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            gap_q   <= ok_i;
        end
    end

    // keep answer while writeback is blocked
    always_ff @(posedge clk) begin
        if (state_q == st_wait && ok_i) begin
            res_q <= acc_res;
        end
    end

endmodule

//--- source/data_mem.sv
`timescale 1ns/1ps

module data_mem (
    input  logic            clk,
    input  logic            rst,

    input  logic            req_i,
    input  pipe_pkg::word_t addr_i,
    input  pipe_pkg::word_t wdata_i,
    input  logic            write_i,
    input  logic [1:0]      size_i,

    output logic            ok_o,
    output pipe_pkg::word_t rdata_o
);

    // little-endian word ram
    pipe_pkg::word_t                 mem [mem_pkg::mem_words];

    logic                            busy_q;
    mem_pkg::lat_cnt_t               cnt_q;
    // request captured on first sight
    logic [mem_pkg::mem_addr_w-1:0]  idx_q;
    logic [1:0]                      lane_q;
    logic [1:0]                      size_q;
    logic                            write_q;
    pipe_pkg::word_t                 wdata_q;
    // per-lane write strobes and replicated data
    logic [3:0]                      be;
    pipe_pkg::word_t                 wlanes;

    assign ok_o    = busy_q && (cnt_q == mem_pkg::lat_done);
    // whole word, sampled by the requester in the ok cycle
    assign rdata_o = mem[idx_q];

    // latency counter, counts from the cycle the request is first seen
    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
        end else if (!busy_q) begin
            busy_q <= req_i;
            cnt_q  <= mem_pkg::lat_cnt_t'(1);
        end else if (ok_o) begin
            busy_q <= 1'b0;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // only accepted while idle
    always_ff @(posedge clk) begin
        if (!busy_q && req_i) begin
            idx_q   <= addr_i[mem_pkg::mem_addr_w+1:2];
            lane_q  <= addr_i[1:0];
            size_q  <= size_i;
            write_q <= write_i;
            wdata_q <= wdata_i;
        end
    end

    // lane select from size and low address bits
    always_comb begin
        case (size_q)
            mem_pkg::size_byte: be = 4'b0001 << lane_q;
            mem_pkg::size_half: be = lane_q[1] ? 4'b1100 : 4'b0011;
            mem_pkg::size_word: be = 4'b1111;
            default:            be = 4'b1111;
        endcase
        case (size_q)
            mem_pkg::size_byte: wlanes = {4{wdata_q[7:0]}};
            mem_pkg::size_half: wlanes = {2{wdata_q[15:0]}};
            default:            wlanes = wdata_q;
        endcase
    end

    // store commits on the ok edge
    always_ff @(posedge clk) begin
        if (ok_o && write_q) begin
            for (int i = 0; i < 4; i++) begin
                if (be[i]) begin
                    mem[idx_q][i*8 +: 8] <= wlanes[i*8 +: 8];
                end
            end
        end
    end

endmodule

//--- source/lsu_pipe.sv
`timescale 1ns/1ps

module lsu_pipe (
    input  logic                clk,
    input  logic                rst,

    input  logic                in_valid_i,
    output logic                in_ready_o,
    input  logic                in_we_i,
    input  pipe_pkg::reg_addr_t in_wa_i,
    input  pipe_pkg::word_t     in_base_i,
    input  pipe_pkg::word_t     in_offset_i,
    input  pipe_pkg::word_t     in_store_data_i,
    input  mem_pkg::mem_op_t    in_mem_op_i,

    output logic                wb_valid_o,
    input  logic                wb_ready_i,
    output logic                wb_we_o,
    output pipe_pkg::reg_addr_t wb_wa_o,
    output pipe_pkg::word_t     wb_data_o
);

    // address stage to ex_buf
    logic                  as_valid;
    logic                  as_ready;
    pipe_pkg::ex_payload_t as_payload;

    // ex_buf to memory stage
    logic                  ex_valid;
    logic                  ex_ready;
    pipe_pkg::ex_payload_t ex_payload;

    // memory stage to wb_buf
    logic                  ms_valid;
    logic                  ms_ready;
    pipe_pkg::wb_payload_t ms_payload;

    // writeback slot
    pipe_pkg::wb_payload_t wb_payload;

    // memory stage to controller
    logic                  mem_req;
    pipe_pkg::word_t       mem_addr;
    pipe_pkg::word_t       mem_wdata;
    logic                  mem_write;
    logic [1:0]            mem_size;
    logic                  mem_ok;
    pipe_pkg::word_t       mem_rdata;

    addr_stage u_addr_stage (
        .clk, .rst, .in_valid_i, .in_ready_o, .in_we_i, .in_wa_i, .in_base_i, .in_offset_i,
        .in_store_data_i, .in_mem_op_i,
        .out_valid_o(as_valid), .out_payload_o(as_payload), .out_ready_i(as_ready)
    );

    stage_buffer #(.payload_t(pipe_pkg::ex_payload_t)) ex_buf (
        .clk, .rst, .in_valid_i(as_valid), .in_payload_i(as_payload), .in_ready_o(as_ready),
        .out_valid_o(ex_valid), .out_payload_o(ex_payload), .out_ready_i(ex_ready)
    );

    mem_stage u_mem_stage (
        .clk, .rst, .in_valid_i(ex_valid), .in_payload_i(ex_payload), .in_ready_o(ex_ready),
        .out_valid_o(ms_valid), .out_payload_o(ms_payload), .out_ready_i(ms_ready),
        .req_o(mem_req), .addr_o(mem_addr), .wdata_o(mem_wdata), .write_o(mem_write),
        .size_o(mem_size), .ok_i(mem_ok), .rdata_i(mem_rdata)
    );

    stage_buffer #(.payload_t(pipe_pkg::wb_payload_t)) wb_buf (
        .clk, .rst, .in_valid_i(ms_valid), .in_payload_i(ms_payload), .in_ready_o(ms_ready),
        .out_valid_o(wb_valid_o), .out_payload_o(wb_payload), .out_ready_i(wb_ready_i)
    );

    data_mem u_data_mem (
        .clk, .rst, .req_i(mem_req), .addr_i(mem_addr), .wdata_i(mem_wdata),
        .write_i(mem_write), .size_i(mem_size), .ok_o(mem_ok), .rdata_o(mem_rdata)
    );

    // writeback fields out as loose ports
    assign wb_we_o   = wb_payload.we;
    assign wb_wa_o   = wb_payload.wa;
    assign wb_data_o = wb_payload.data;

endmodule

//--- bench/lsu_ref_model.svh
`ifndef LSU_REF_MODEL_SVH
`define LSU_REF_MODEL_SVH

// byte-wide shadow of the little-endian data ram
logic [7:0] shadow [mem_pkg::mem_words][4];

// only the lanes of the access change
function automatic void store_to_shadow(input logic [31:0] addr, input logic [31:0] data,
                                        input logic [1:0] size);
    int w;
    int l;
    w = int'(addr[9:2]);
    l = int'(addr[1:0]);
    if (size == mem_pkg::size_byte) begin
        shadow[w][l] = data[7:0];
    end else if (size == mem_pkg::size_half) begin
        // bit 0 has no effect on a halfword
        l = addr[1] ? 2 : 0;
        shadow[w][l]     = data[7:0];
        shadow[w][l + 1] = data[15:8];
    end else begin
        for (int i = 0; i < 4; i++) begin
            shadow[w][i] = data[i*8 +: 8];
        end
    end
endfunction

// lane pick plus sign or zero fill
// word size ignores uns
function automatic logic [31:0] load_from_shadow(input logic [31:0] addr,
                                                 input logic [1:0] size, input logic uns);
    int          w;
    logic [7:0]  b;
    logic [15:0] h;
    w = int'(addr[9:2]);
    b = shadow[w][int'(addr[1:0])];
    h = addr[1] ? {shadow[w][3], shadow[w][2]} : {shadow[w][1], shadow[w][0]};
    if (size == mem_pkg::size_byte) begin
        return uns ? {24'h0, b} : {{24{b[7]}}, b};
    end else if (size == mem_pkg::size_half) begin
        return uns ? {16'h0, h} : {{16{h[15]}}, h};
    end
    return {shadow[w][3], shadow[w][2], shadow[w][1], shadow[w][0]};
endfunction

`endif

//--- bench/lsu_pipe_tb.sv
`timescale 1ns/1ps

module lsu_pipe_tb;

    // directed plus random operation count
    localparam int n_ops = 65 + 300;
    localparam longint timeout_ns = longint'(n_ops * 5 + 200) * 40;

    logic             clk;
    logic             rst;
    logic             in_valid_i;
    logic             in_ready_o;
    logic             in_we_i;
    logic [4:0]       in_wa_i;
    logic [31:0]      in_base_i;
    logic [31:0]      in_offset_i;
    logic [31:0]      in_store_data_i;
    mem_pkg::mem_op_t in_mem_op_i;
    logic             wb_valid_o;
    logic             wb_ready_i;
    logic             wb_we_o;
    logic [4:0]       wb_wa_o;
    logic [31:0]      wb_data_o;

    integer      seed = 60006;
    logic        rand_ready;
    logic        ready_fixed;
    logic        hold_q;
    logic        prev_we;
    logic [4:0]  prev_wa;
    logic [31:0] prev_data;
    logic [31:0] r;
    int          cyc;
    int          sent_count;
    int          out_count;
    int          t_in;
    int          lat;
    logic [31:0] exp_data_q[$];
    logic        exp_we_q[$];
    logic [4:0]  exp_wa_q[$];
    int          exp_lat_q[$];
    int          in_cyc_q[$];

    `include "lsu_ref_model.svh"

    lsu_pipe DUT (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            $display("Fail at %0t ns: %s expected %h got %h", $time, name, exp, act);
            report_failure("wrong value at the writeback port");
        end
    endtask

    function automatic mem_pkg::mem_op_t make_op(input logic acc, input logic [1:0] size,
                                                 input logic wr, input logic uns);
        mem_pkg::mem_op_t op;
        op = '0;
        op[mem_pkg::op_access_bit] = acc;
        op[mem_pkg::op_size_hi:mem_pkg::op_size_lo] = size;
        op[mem_pkg::op_write_bit] = wr;
        op[mem_pkg::op_unsigned_bit] = uns;
        return op;
    endfunction

    // expected value formed in input order
    // op held on the inputs until taken
    task automatic send_op(input logic we, input logic [4:0] wa, input logic [31:0] base,
                           input logic [31:0] off, input logic [31:0] sd,
                           input mem_pkg::mem_op_t op, input int exp_lat);
        logic [31:0] addr;
        logic [1:0]  size;
        addr = base + off;
        size = op[mem_pkg::op_size_hi:mem_pkg::op_size_lo];
        if (op[mem_pkg::op_access_bit] && !op[mem_pkg::op_write_bit]) begin
            exp_data_q.push_back(load_from_shadow(addr, size, op[mem_pkg::op_unsigned_bit]));
        end else begin
            exp_data_q.push_back(addr);
            if (op[mem_pkg::op_access_bit]) store_to_shadow(addr, sd, size);
        end
        exp_we_q.push_back(we);
        exp_wa_q.push_back(wa);
        exp_lat_q.push_back(exp_lat);
        in_valid_i <= 1'b1;
        in_we_i <= we;
        in_wa_i <= wa;
        in_base_i <= base;
        in_offset_i <= off;
        in_store_data_i <= sd;
        in_mem_op_i <= op;
        @(posedge clk);
        while (!in_ready_o) @(posedge clk);
        sent_count++;
    endtask

    task automatic drain_pipe();
        in_valid_i <= 1'b0;
        wait (out_count == sent_count);
        @(posedge clk);
    endtask

    // wb_ready_i either random or fixed
    always @(posedge clk) begin
        if (rand_ready) begin
            r = $random(seed);
            wb_ready_i <= (r[1:0] != 2'b00);
        end else begin
            wb_ready_i <= ready_fixed;
        end
    end

    // reads the values settled before this edge
    always @(posedge clk) begin
        cyc++;
        if (!rst) begin
            if (in_valid_i && in_ready_o) in_cyc_q.push_back(cyc);
            if (hold_q) begin
                assert (wb_valid_o) else report_failure("wb_valid_o dropped under back-pressure");
                check_value("wb_we_o (held)", 32'(prev_we), 32'(wb_we_o));
                check_value("wb_wa_o (held)", 32'(prev_wa), 32'(wb_wa_o));
                check_value("wb_data_o (held)", prev_data, wb_data_o);
            end
            if (wb_valid_o && wb_ready_i) begin
                assert (exp_data_q.size() > 0) else report_failure("output with no op sent");
                t_in = in_cyc_q.pop_front();
                lat = exp_lat_q.pop_front();
                check_value("wb_we_o", 32'(exp_we_q.pop_front()), 32'(wb_we_o));
                check_value("wb_wa_o", 32'(exp_wa_q.pop_front()), 32'(wb_wa_o));
                check_value("wb_data_o", exp_data_q.pop_front(), wb_data_o);
                if (lat != 0) check_value("wb_valid_o latency", 32'(lat), 32'(cyc - t_in));
                out_count++;
            end
            hold_q = wb_valid_o && !wb_ready_i;
            prev_we = wb_we_o;
            prev_wa = wb_wa_o;
            prev_data = wb_data_o;
        end
    end

    initial begin
        #(timeout_ns);
        report_failure("timeout, the pipeline stopped producing results");
    end

    initial begin
        rst <= 1'b1;
        in_valid_i <= 1'b0;
        in_we_i <= 1'b0;
        in_wa_i <= '0;
        in_base_i <= '0;
        in_offset_i <= '0;
        in_store_data_i <= '0;
        in_mem_op_i <= '0;
        wb_ready_i <= 1'b1;
        rand_ready <= 1'b0;
        ready_fixed <= 1'b1;
        hold_q = 1'b0;
        cyc = 0;
        sent_count = 0;
        out_count = 0;
        // reset state checked on the later reset edges and just after
        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
            if (i == 2) rst <= 1'b0;
            if (i > 0) begin
                assert (!wb_valid_o && in_ready_o) else report_failure("bad state in reset");
            end
        end
        // isolated and back-to-back pass-through
        send_op(1'b1, 5'd3, 32'h1000, 32'h24, 32'h0, make_op(0, 2'd0, 0, 0), 3);
        drain_pipe();
        for (int i = 0; i < 6; i++) begin
            send_op(i[0], 5'(i + 1), 32'h40 * i, 32'h7, 32'h0, make_op(0, 2'd0, 0, 0), 3);
        end
        drain_pipe();
        // isolated word store then load
        send_op(1'b0, 5'd0, 32'h200, 32'h0, 32'hcafe_f00d,
                make_op(1, mem_pkg::size_word, 1, 0), 5);
        drain_pipe();
        send_op(1'b1, 5'd9, 32'h200, 32'h0, 32'h0, make_op(1, mem_pkg::size_word, 0, 1), 5);
        drain_pipe();
        // every word of the random window gets written first
        for (int i = 0; i < 16; i++) begin
            send_op(1'b0, 5'd0, {22'h0, 4'h8, 4'(i), 2'b00}, 32'h0, 32'h1357_9bdf * (i + 1),
                    make_op(1, mem_pkg::size_word, 1, 0), 0);
        end
        // byte lanes with signed and unsigned loads
        // word load shows the untouched lanes
        for (int l = 0; l < 4; l++) begin
            send_op(1'b0, 5'd0, 32'h204, 32'(l), 32'h80 | (l * 3),
                    make_op(1, mem_pkg::size_byte, 1, 0), 0);
            send_op(1'b1, 5'd4, 32'h204, 32'(l), 0, make_op(1, mem_pkg::size_byte, 0, 0), 0);
            send_op(1'b1, 5'd5, 32'h204, 32'(l), 0, make_op(1, mem_pkg::size_byte, 0, 1), 0);
            send_op(1'b1, 5'd6, 32'h204, 32'h0, 0, make_op(1, mem_pkg::size_word, 0, 0), 0);
        end
        // halfwords where odd offsets ignore bit 0
        for (int l = 0; l < 4; l++) begin
            send_op(1'b0, 5'd0, 32'h208, 32'(l), 32'h9a00 + l,
                    make_op(1, mem_pkg::size_half, 1, 0), 0);
            send_op(1'b1, 5'd7, 32'h208, 32'(l), 0, make_op(1, mem_pkg::size_half, 0, 0), 0);
            send_op(1'b1, 5'd8, 32'h208, 32'(l ^ 1), 0, make_op(1, mem_pkg::size_half, 0, 1), 0);
            send_op(1'b1, 5'd6, 32'h208, 32'h0, 0, make_op(1, mem_pkg::size_word, 0, 1), 0);
        end
        drain_pipe();
        // stall the output and release it later
        ready_fixed <= 1'b0;
        fork
            begin
                for (int i = 0; i < 8; i++) begin
                    send_op(1'b1, 5'(i), 32'h20c, 32'(i % 4), 32'hff - i,
                            make_op(i[0], 2'(i % 4), i[1], 0), 0);
                end
            end
            begin
                repeat (20) @(posedge clk);
                ready_fixed <= 1'b1;
            end
        join
        drain_pipe();
        // random mix on the 16-word window
        rand_ready <= 1'b1;
        for (int i = 0; i < 300; i++) begin
            logic [31:0] a;
            logic [31:0] b;
            a = $random(seed);
            b = $random(seed);
            case (a[2:0])
                3'd0, 3'd7: send_op(a[3], a[8:4], b, $random(seed), 0, make_op(0, 0, 0, 0), 0);
                3'd1, 3'd2, 3'd3: send_op(a[3], a[8:4], {b[31:10], 4'h8, a[12:9], 2'b00},
                    32'(a[14:13]), $random(seed), make_op(1, a[2:0] == 3'd3 ? 2'd3 : 2'(a[1]),
                    1, a[15]), 0);
                default: send_op(a[3], a[8:4], {b[31:10], 4'h8, a[12:9], 2'b00},
                    32'(a[14:13]), 0, make_op(1, a[2:0] == 3'd6 ? 2'd3 : 2'(a[0]), 0, a[15]), 0);
            endcase
        end
        rand_ready <= 1'b0;
        ready_fixed <= 1'b1;
        drain_pipe();
        repeat (5) @(posedge clk);
        if (out_count == sent_count && exp_data_q.size() == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            report_failure("output count does not match input count");
        end
    end

endmodule

//--- lsu_pipe.f
+incdir+bench
source/mem_pkg.sv
source/pipe_pkg.sv
source/stage_buffer.sv
source/addr_stage.sv
source/mem_stage.sv
source/data_mem.sv
source/lsu_pipe.sv
bench/lsu_pipe_tb.sv

//--- run.sh
#!/usr/bin/env bash
# builds and runs the lsu_pipe testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module lsu_pipe_tb -f lsu_pipe.f \
    --Mdir obj_dir -o lsu_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out="$(./obj_dir/lsu_sim)"
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation returned an error"
    exit 1
fi

if echo "$out" | grep -q "Everything OK"; then
    exit 0
fi
exit 1
